// ==== Makefile ====
TOP := cpuTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

// ==== bench/cpuProperties.sv ====
// Concurrent checks on the AXI handshakes and the request done pulse of the memory port
`timescale 1ns/1ps

module cpuProperties (
  input logic clock,
  input logic arstN,
  input logic arValid,
  input logic arReady,
  input logic awValid,
  input logic awReady,
  input logic wValid,
  input logic wReady,
  input logic rValid,
  input logic rReady,
  input logic bValid,
  input logic bReady,
  input logic memDone
);

  int failCount = 0; // Read by the testbench at the end

  property holdUntilReady(logic valid, logic ready);
    @(posedge clock) disable iff (!arstN) valid && !ready |=> valid;
  endproperty

  arHold: assert property (holdUntilReady(arValid, arReady))
    else
    begin
      failCount++;
      $error("arValid dropped before arReady");
    end
  awHold: assert property (holdUntilReady(awValid, awReady))
    else
    begin
      failCount++;
      $error("awValid dropped before awReady");
    end
  wHold: assert property (holdUntilReady(wValid, wReady))
    else
    begin
      failCount++;
      $error("wValid dropped before wReady");
    end
  rHold: assert property (holdUntilReady(rValid, rReady)) // Slave side
    else
    begin
      failCount++;
      $error("rValid dropped before rReady");
    end
  bHold: assert property (holdUntilReady(bValid, bReady))
    else
    begin
      failCount++;
      $error("bValid dropped before bReady");
    end

  donePulse: assert property (@(posedge clock) disable iff (!arstN) memDone |=> !memDone)
    else
    begin
      failCount++;
      $error("memDone high for two cycles");
    end

  // One request outstanding, so never both address channels
  oneRequest: assert property (@(posedge clock) disable iff (!arstN) !(arValid && awValid))
    else
    begin
      failCount++;
      $error("arValid and awValid high together");
    end

endmodule

// ==== bench/cpuTb.sv ====
// Testbench for the CPU with AXI slave memory, ISA reference model and directed tests
`timescale 1ns/1ps

module cpuTb;

  logic        clock;
  logic        arstN;
  logic        run;
  logic        done;
  logic [31:0] awAddr;
  logic        awValid;
  logic        awReady;
  logic [31:0] wData;
  logic [3:0]  wStrb;
  logic        wValid;
  logic        wReady;
  logic [1:0]  bResp;
  logic        bValid;
  logic        bReady;
  logic [31:0] arAddr;
  logic        arValid;
  logic        arReady;
  logic [31:0] rData;
  logic [1:0]  rResp;
  logic        rValid;
  logic        rReady;

  cpuPkg::memWordT memory [256]; // Slave side words
  logic [15:0]     refMem [256]; // Model image
  logic [15:0]     prog [$];     // Program being built
  logic [31:0]     lfsr = 32'haed439b2;
  logic            stall;        // Random back-pressure
  int              instCount;
  int              modelStores;
  int              writeCount;
  int              checkCount;
  int              errorCount;
  int              budget = 100; // Watchdog cycles, grows per program
  string           testName;

  cpuTop dut (.*);

  bind memPort cpuProperties props (
    .clock   (clock),
    .arstN   (arstN),
    .arValid (arValid),
    .arReady (arReady),
    .awValid (awValid),
    .awReady (awReady),
    .wValid  (wValid),
    .wReady  (wReady),
    .rValid  (rValid),
    .rReady  (rReady),
    .bValid  (bValid),
    .bReady  (bReady),
    .memDone (mem.memDone)
  );

  always #4 clock = ~clock; // 8 ns period

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic lfsrStep();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic int pickDelay(); // 0..3 cycles
    logic [1:0] d;
    if (!stall)
      return 0;
    d[0] = lfsrStep();
    d[1] = lfsrStep();
    return int'(d);
  endfunction

  // Read slave, AR ready then R valid
  initial
  begin
    logic [7:0] rdIndex;
    forever
    begin
      @(negedge clock);
      if (arValid)
      begin
        rdIndex = arAddr[9:2];
        repeat (pickDelay()) @(posedge clock);
        @(posedge clock);
        #1 arReady = 1'b1;
        @(posedge clock);
        #1 arReady = 1'b0;
        repeat (pickDelay()) @(posedge clock);
        @(posedge clock);
        #1 rValid = 1'b1;
        rData = {16'h0000, memory[rdIndex].data};
        do
          @(negedge clock);
        while (!rReady);
        @(posedge clock);
        #1 rValid = 1'b0;
      end
    end
  end

  // Write slave, AW and W ready on their own delays, then B
  initial
  begin
    logic [7:0]  wrIndex;
    logic [15:0] wrWord;
    forever
    begin
      @(negedge clock);
      if (awValid && wValid)
      begin
        wrIndex    = awAddr[9:2];
        wrWord     = wData[15:0];
        checkCount += 2;
        if (wStrb != 4'b0011)
        begin
          errorCount++;
          $display("error %s: wStrb expected %b actual %b", testName, 4'b0011, wStrb);
        end
        if (awAddr[1:0] != 2'b00)
        begin
          errorCount++;
          $display("%s: write address %h is not a multiple of 4", testName, awAddr);
        end
        fork
          begin
            repeat (pickDelay()) @(posedge clock);
            @(posedge clock);
            #1 awReady = 1'b1;
            @(posedge clock);
            #1 awReady = 1'b0;
          end
          begin
            repeat (pickDelay()) @(posedge clock);
            @(posedge clock);
            #1 wReady = 1'b1;
            @(posedge clock);
            #1 wReady = 1'b0;
          end
        join
        memory[wrIndex].data = wrWord;
        writeCount++;
        repeat (pickDelay()) @(posedge clock);
        @(posedge clock);
        #1 bValid = 1'b1;
        do
          @(negedge clock);
        while (!bReady);
        @(posedge clock);
        #1 bValid = 1'b0;
      end
    end
  end

  // ISA model over refMem, fields {6 unused, opcode, rx, ry}
  task automatic runModel();
    logic [15:0] r [8];
    logic [15:0] g;
    logic [15:0] word;
    logic [3:0]  op;
    logic [2:0]  x;
    logic [2:0]  y;
    int          n;
    for (n = 0; n < 8; n++)
      r[n] = '0;
    g           = '0; // G clears on reset
    modelStores = 0;
    for (n = 0; n < instCount; n++)
    begin
      word = refMem[r[7][7:0]];
      r[7] = r[7] + 16'd1;
      op   = word[9:6];
      x    = word[5:3];
      y    = word[2:0];
      case (op)
        cpuPkg::opMv:   r[x] = r[y];
        cpuPkg::opMvi:
        begin
          r[x] = refMem[r[7][7:0]]; // Immediate follows opcode
          r[7] = r[7] + 16'd1;
        end
        cpuPkg::opMvnz: if (g != 16'd0) r[x] = r[y];
        cpuPkg::opAdd:  g = r[x] + r[y];
        cpuPkg::opSub:  g = r[x] - r[y];
        cpuPkg::opSlt:  g = {15'd0, $signed(r[x]) < $signed(r[y])};
        cpuPkg::opCmp:  g = {15'd0, r[x] == r[y]};
        cpuPkg::opLd:   r[x] = refMem[r[y][7:0]];
        cpuPkg::opSt:
        begin
          refMem[r[y][7:0]] = r[x];
          modelStores++;
        end
        default: ;
      endcase
      if (op >= cpuPkg::opAdd && op <= cpuPkg::opCmp)
        r[x] = g; // Result lands in Rx through G
    end
  endtask

  task automatic newProgram(input string name);
    testName  = name;
    instCount = 0;
    prog.delete();
  endtask

  task automatic putOp(input logic [3:0] op, input int x, input int y);
    prog.push_back({6'b000000, op, x[2:0], y[2:0]});
    instCount++;
  endtask

  task automatic putMvi(input int x, input logic [15:0] imm);
    putOp(cpuPkg::opMvi, x, 0);
    prog.push_back(imm);
  endtask

  task automatic applyReset();
    @(posedge clock);
    #1 arstN = 1'b0;
    repeat (16) @(posedge clock);
    #1 arstN = 1'b1;
  endtask

  // Load, run to the last done, then compare against the model
  task automatic runProgram();
    int a;
    int doneCount;
    doneCount = 0;
    for (a = 0; a < 256; a++)
    begin
      memory[a[7:0]].data = {a[7:0] ^ 8'h3C, ~a[7:0]}; // Fill from whole address
      refMem[a[7:0]]      = memory[a[7:0]].data;
    end
    for (a = 0; a < prog.size(); a++)
    begin
      memory[a[7:0]].data = prog[a];
      refMem[a[7:0]]      = prog[a];
    end
    runModel();
    budget     += 200 * instCount + 64; // Reset and idle window
    writeCount = 0;
    applyReset();
    @(posedge clock);
    #1 run = 1'b1;
    while (doneCount < instCount)
    begin
      @(negedge clock);
      if (done)
        doneCount++;
    end
    @(posedge clock);
    #1 run = 1'b0;
    repeat (12)
    begin
      @(negedge clock);
      checkCount++;
      if (arValid)
      begin
        errorCount++;
        $display("%s: read address issued after run fell", testName);
      end
    end
    checkCount++;
    if (writeCount != modelStores)
    begin
      errorCount++;
      $display("error %s: writes expected %0d actual %0d", testName, modelStores, writeCount);
    end
    for (a = 0; a < 256; a++)
    begin
      checkCount++;
      if (memory[a[7:0]].data !== refMem[a[7:0]])
      begin
        errorCount++;
        $display("error %s: mem[%02h] expected %04h actual %04h", testName, a[7:0],
                 refMem[a[7:0]], memory[a[7:0]].data);
      end
    end
  endtask

  task automatic mviStoreTest(input string name);
    newProgram(name);
    putMvi(0, 16'h1234);
    putMvi(1, 16'h0080);
    putOp(cpuPkg::opSt, 0, 1);
    putMvi(2, 16'hBEEF);
    putMvi(3, 16'h0081);
    putOp(cpuPkg::opSt, 2, 3);
    putMvi(4, 16'h0000);
    putMvi(5, 16'h0082);
    putOp(cpuPkg::opSt, 4, 5);
    putMvi(6, 16'hFFFF);
    putMvi(0, 16'h0083);
    putOp(cpuPkg::opSt, 6, 0);
    runProgram();
  endtask

  task automatic moveTest(input string name);
    newProgram(name);
    putMvi(1, 16'h5A5A);
    putOp(cpuPkg::opMv, 2, 1);
    putMvi(0, 16'h0090);
    putOp(cpuPkg::opSt, 2, 0);
    putMvi(3, 16'h0005);
    putMvi(4, 16'h0005);
    putOp(cpuPkg::opCmp, 3, 4); // G nonzero
    putMvi(5, 16'h1111);
    putMvi(6, 16'h2222);
    putOp(cpuPkg::opMvnz, 5, 6);
    putMvi(0, 16'h0091);
    putOp(cpuPkg::opSt, 5, 0);
    putMvi(3, 16'h0001);
    putMvi(4, 16'h0002);
    putOp(cpuPkg::opCmp, 3, 4); // G zero, R5 must stay
    putMvi(5, 16'h3333);
    putOp(cpuPkg::opMvnz, 5, 6);
    putMvi(0, 16'h0092);
    putOp(cpuPkg::opSt, 5, 0);
    runProgram();
  endtask

  task automatic arithTest(input string name);
    newProgram(name);
    putMvi(0, 16'hFFFF);
    putMvi(1, 16'h0002);
    putOp(cpuPkg::opAdd, 0, 1); // Wraps to 1
    putMvi(2, 16'h0000);
    putMvi(3, 16'h0001);
    putOp(cpuPkg::opSub, 2, 3); // Wraps to FFFF
    putMvi(4, 16'h1234);
    putMvi(5, 16'h0234);
    putOp(cpuPkg::opSub, 4, 5);
    putMvi(6, 16'h00A0);
    putOp(cpuPkg::opSt, 0, 6);
    putMvi(6, 16'h00A1);
    putOp(cpuPkg::opSt, 2, 6);
    putMvi(6, 16'h00A2);
    putOp(cpuPkg::opSt, 4, 6);
    runProgram();
  endtask

  task automatic compareTest(input string name);
    newProgram(name);
    putMvi(0, 16'h8000);
    putMvi(1, 16'h0001);
    putOp(cpuPkg::opSlt, 0, 1); // Negative less than 1
    putMvi(2, 16'h0001);
    putMvi(3, 16'h8000);
    putOp(cpuPkg::opSlt, 2, 3);
    putMvi(4, 16'h7FFF);
    putMvi(5, 16'h7FFF);
    putOp(cpuPkg::opCmp, 4, 5);
    putMvi(1, 16'h0003);
    putMvi(3, 16'h0004);
    putOp(cpuPkg::opCmp, 1, 3);
    putMvi(6, 16'h00B0);
    putOp(cpuPkg::opSt, 0, 6);
    putMvi(6, 16'h00B1);
    putOp(cpuPkg::opSt, 2, 6);
    putMvi(6, 16'h00B2);
    putOp(cpuPkg::opSt, 4, 6);
    putMvi(6, 16'h00B3);
    putOp(cpuPkg::opSt, 1, 6);
    runProgram();
  endtask

  task automatic loadTest(input string name);
    newProgram(name);
    putMvi(0, 16'h00C0);
    putOp(cpuPkg::opLd, 1, 0); // Fill word
    putMvi(2, 16'h00C8);
    putOp(cpuPkg::opSt, 1, 2);
    putMvi(3, 16'h4321);
    putMvi(4, 16'h00C4);
    putOp(cpuPkg::opSt, 3, 4);
    putOp(cpuPkg::opLd, 5, 4); // Read back own store
    putMvi(6, 16'h00C5);
    putOp(cpuPkg::opSt, 5, 6);
    runProgram();
  endtask

  task automatic stressTest();
    stall = 1'b1;
    mviStoreTest("mviStore stalled");
    moveTest("move stalled");
    arithTest("arith stalled");
    compareTest("compare stalled");
    loadTest("load stalled");
    stall = 1'b0;
  endtask

  initial
  begin
    clock      = 1'b0;
    arstN      = 1'b0;
    run        = 1'b0;
    awReady    = 1'b0;
    wReady     = 1'b0;
    bResp      = cpuPkg::axiRespOkay;
    bValid     = 1'b0;
    arReady    = 1'b0;
    rData      = '0;
    rResp      = cpuPkg::axiRespOkay;
    rValid     = 1'b0;
    stall      = 1'b0;
    checkCount = 0;
    errorCount = 0;
    mviStoreTest("mviStore");
    moveTest("move");
    arithTest("arith");
    compareTest("compare");
    loadTest("load");
    stressTest();
    checkCount++;
    if (dut.uMem.props.failCount != 0)
    begin
      errorCount += dut.uMem.props.failCount;
      $display("%0d AXI handshake assertions failed", dut.uMem.props.failCount);
    end
    $display("checks %0d, errors %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

  // Watchdog, budget grows with each program's length
  initial
  begin
    int cycles;
    cycles = 0;
    while (cycles <= budget)
    begin
      @(posedge clock);
      cycles++;
    end
    $display("timeout in %s after %0d cycles without finishing", testName, cycles);
    $display("checks %0d, errors %0d", checkCount, errorCount + 1);
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== hw/controlUnit.sv ====
// Control unit with step counter, instruction register and per-opcode sequencing
`timescale 1ns/1ps

module controlUnit (
  input  logic   clock,
  input  logic   arstN,
  cpuCtrlIf.ctrl ctl,
  memReqIf.req   mem,
  input  logic   run,
  output logic   done
);

  cpuPkg::memWordT              ir;       // Instruction register
  logic [cpuPkg::stepWidth-1:0] step;     // T0..T5
  logic [cpuPkg::numRegs-1:0]   rxSel;    // One-hot Rx
  logic [cpuPkg::numRegs-1:0]   rySel;    // One-hot Ry
  logic [cpuPkg::numRegs-1:0]   pcSel;    // One-hot R7
  logic                         irIn;
  logic                         advance;  // Go to next step
  logic                         finish;   // Last step, back to T0
  logic                         readStep; // Step that issues a read and waits
  logic                         rdBusy;   // Read outstanding

  always_comb
  begin
    rxSel = '0;
    rySel = '0;
    pcSel = '0;
    rxSel[ir.fields.rx] = 1'b1;
    rySel[ir.fields.ry] = 1'b1;
    pcSel[cpuPkg::pcIndex] = 1'b1;
  end

  always_comb
  begin
    ctl.rIn     = '0;
    ctl.rOut    = '0;
    ctl.dinOut  = 1'b0;
    ctl.gOut    = 1'b0;
    ctl.aIn     = 1'b0;
    ctl.gIn     = 1'b0;
    ctl.addrIn  = 1'b0;
    ctl.doutIn  = 1'b0;
    ctl.incrPc  = 1'b0;
    ctl.aluOp   = cpuPkg::aluAdd;
    mem.rdStart = 1'b0;
    mem.wrStart = 1'b0;
    irIn        = 1'b0;
    readStep    = 1'b0;
    advance     = 1'b1;
    finish      = 1'b0;
    case (step)
      3'd0:
        if (run)
        begin
          ctl.rOut   = pcSel; // PC to ADDR for fetch
          ctl.addrIn = 1'b1;
        end
        else
          advance = 1'b0; // Idle, no further fetches
      3'd1: readStep = 1'b1; // Instruction fetch
      3'd2:
      begin
        irIn       = 1'b1; // IR from read data
        ctl.incrPc = 1'b1;
      end
      3'd3:
        case (ir.fields.opcode)
          cpuPkg::opMv:
          begin
            ctl.rIn  = rxSel;
            ctl.rOut = rySel;
            finish   = 1'b1;
          end
          cpuPkg::opMvnz:
          begin
            ctl.rIn  = rxSel;
            ctl.rOut = ctl.gNonZero ? rySel : rxSel; // Zero G keeps Rx
            finish   = 1'b1;
          end
          cpuPkg::opMvi:
          begin
            ctl.rOut   = pcSel; // Immediate sits at PC
            ctl.addrIn = 1'b1;
          end
          cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opSlt, cpuPkg::opCmp:
          begin
            ctl.rOut = rxSel; // First operand into A
            ctl.aIn  = 1'b1;
          end
          cpuPkg::opLd:
          begin
            ctl.rOut   = rySel; // Pointer into ADDR
            ctl.addrIn = 1'b1;
          end
          cpuPkg::opSt:
          begin
            ctl.rOut   = rxSel; // Store data into DOUT
            ctl.doutIn = 1'b1;
          end
          default: finish = 1'b1; // Unknown opcode runs as nop
        endcase
      3'd4:
        case (ir.fields.opcode)
          cpuPkg::opMvi, cpuPkg::opLd: readStep = 1'b1;
          cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opSlt, cpuPkg::opCmp:
          begin
            ctl.rOut = rySel; // Second operand straight from bus
            ctl.gIn  = 1'b1;
            ctl.aluOp = 2'(ir.fields.opcode - cpuPkg::opAdd); // add..cmp follow opAdd in order
          end
          cpuPkg::opSt:
          begin
            ctl.rOut    = rySel; // Address into ADDR
            ctl.addrIn  = 1'b1;
            mem.wrStart = 1'b1; // AXI valids rise once ADDR is loaded
          end
          default: finish = 1'b1;
        endcase
      3'd5:
        case (ir.fields.opcode)
          cpuPkg::opMvi:
          begin
            ctl.rIn    = rxSel;
            ctl.dinOut = 1'b1;
            ctl.incrPc = 1'b1; // Skip over the immediate
            finish     = 1'b1;
          end
          cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opSlt, cpuPkg::opCmp:
          begin
            ctl.rIn  = rxSel; // Rx <- G
            ctl.gOut = 1'b1;
            finish   = 1'b1;
          end
          cpuPkg::opLd:
          begin
            ctl.rIn    = rxSel;
            ctl.dinOut = 1'b1;
            finish     = 1'b1;
          end
          cpuPkg::opSt:
          begin
            advance = 1'b0; // Hold for write response
            finish  = mem.memDone;
          end
          default: finish = 1'b1;
        endcase
      default: finish = 1'b1; // Unreachable steps fall back to fetch
    endcase
    if (readStep)
    begin
      mem.rdStart = !rdBusy; // Pulse once, then wait
      advance     = mem.memDone;
    end
    done = finish;
  end

  always_ff @(posedge clock or negedge arstN)
  begin
    if (!arstN)
    begin
      step   <= '0;
      rdBusy <= 1'b0;
    end
    else
    begin
      if (finish)
        step <= '0;
      else if (advance)
        step <= step + 1'b1;
      if (mem.rdStart)
        rdBusy <= 1'b1;
      else if (mem.memDone)
        rdBusy <= 1'b0;
    end
  end

  always_ff @(posedge clock)
  begin
    if (irIn)
      ir.data <= mem.rdata;
  end

endmodule

// ==== hw/cpuIfs.sv ====
// Control-to-datapath strobes and the single-request memory interface
`timescale 1ns/1ps

interface cpuCtrlIf;
  logic [cpuPkg::numRegs-1:0]    rIn;      // Register load, one-hot
  logic [cpuPkg::numRegs-1:0]    rOut;     // Register onto bus, one-hot
  logic                          dinOut;   // Memory read data onto bus
  logic                          gOut;     // G onto bus
  logic                          aIn;      // Load A
  logic                          gIn;      // Load G from ALU
  logic                          addrIn;   // Load ADDR
  logic                          doutIn;   // Load DOUT
  logic                          incrPc;   // R7 + 1
  logic [cpuPkg::aluOpWidth-1:0] aluOp;
  logic                          gNonZero; // For mvnz

  modport ctrl (
    output rIn, rOut, dinOut, gOut, aIn, gIn, addrIn, doutIn, incrPc, aluOp,
    input  gNonZero
  );
  modport data (
    input  rIn, rOut, dinOut, gOut, aIn, gIn, addrIn, doutIn, incrPc, aluOp,
    output gNonZero
  );
endinterface

interface memReqIf;
  logic                         rdStart; // One-cycle pulse
  logic                         wrStart; // One-cycle pulse
  logic                         memDone; // Cycle after last handshake
  logic [cpuPkg::dataWidth-1:0] rdata;   // Last read word
  logic [cpuPkg::dataWidth-1:0] addr;    // Word address from ADDR
  logic [cpuPkg::dataWidth-1:0] wdata;   // From DOUT

  modport req  (output rdStart, wrStart, input memDone, rdata);
  modport port (input rdStart, wrStart, addr, wdata, output memDone, rdata);
  modport src  (output addr, wdata, input rdata);
endinterface

// ==== hw/cpuPkg.sv ====
// CPU package with ISA opcodes, field widths, ALU codes, AXI constants and the memory word
package cpuPkg;

  localparam int dataWidth    = 16; // Bus and register width
  localparam int axiDataWidth = 32; // Only low half carries data
  localparam int axiAddrWidth = 32; // Byte address = word address << 2
  localparam int numRegs      = 8;  // R0..R7
  localparam int pcIndex      = 7;  // R7 is the program counter
  localparam int opcodeWidth  = 4;
  localparam int regSelWidth  = 3;
  localparam int stepWidth    = 3;  // T0..T5
  localparam int aluOpWidth   = 2;

  // Opcodes 0 to 8, no push or pop
  localparam logic [opcodeWidth-1:0] opMv   = 4'd0; // Rx <- Ry
  localparam logic [opcodeWidth-1:0] opMvi  = 4'd1; // Rx <- imm
  localparam logic [opcodeWidth-1:0] opMvnz = 4'd2; // Rx <- Ry if G != 0
  localparam logic [opcodeWidth-1:0] opAdd  = 4'd3;
  localparam logic [opcodeWidth-1:0] opSub  = 4'd4;
  localparam logic [opcodeWidth-1:0] opSlt  = 4'd5; // Signed less than
  localparam logic [opcodeWidth-1:0] opCmp  = 4'd6; // Equality
  localparam logic [opcodeWidth-1:0] opLd   = 4'd7; // Rx <- mem[Ry]
  localparam logic [opcodeWidth-1:0] opSt   = 4'd8; // mem[Ry] <- Rx

  localparam logic [aluOpWidth-1:0] aluAdd = 2'd0;
  localparam logic [aluOpWidth-1:0] aluSub = 2'd1;
  localparam logic [aluOpWidth-1:0] aluSlt = 2'd2;
  localparam logic [aluOpWidth-1:0] aluCmp = 2'd3;

  localparam logic [1:0] axiRespOkay = 2'b00;

  // One memory word, seen as an instruction or as plain data
  typedef union packed {
    struct packed {
      logic [dataWidth-opcodeWidth-2*regSelWidth-1:0] unused; // Top 6 bits
      logic [opcodeWidth-1:0]                         opcode;
      logic [regSelWidth-1:0]                         rx;     // Destination
      logic [regSelWidth-1:0]                         ry;     // Source
    } fields;
    logic [dataWidth-1:0] data;
  } memWordT;

endpackage

// ==== hw/cpuTop.sv ====
// CPU top level joining control, datapath and the AXI4-Lite memory port
`timescale 1ns/1ps

module cpuTop (
  input  logic                            clock,
  input  logic                            arstN,
  input  logic                            run,     // Keep fetching while high
  output logic                            done,    // Last step of an instruction
  output logic [cpuPkg::axiAddrWidth-1:0] awAddr,
  output logic                            awValid,
  input  logic                            awReady,
  output logic [cpuPkg::axiDataWidth-1:0] wData,
  output logic [3:0]                      wStrb,
  output logic                            wValid,
  input  logic                            wReady,
  input  logic [1:0]                      bResp,
  input  logic                            bValid,
  output logic                            bReady,
  output logic [cpuPkg::axiAddrWidth-1:0] arAddr,
  output logic                            arValid,
  input  logic                            arReady,
  input  logic [cpuPkg::axiDataWidth-1:0] rData,
  input  logic [1:0]                      rResp,
  input  logic                            rValid,
  output logic                            rReady
);

  cpuCtrlIf ctlBus (); // Strobes and gNonZero
  memReqIf  memBus (); // Read and write requests

  controlUnit uCtrl (
    .clock (clock),
    .arstN (arstN),
    .ctl   (ctlBus.ctrl),
    .mem   (memBus.req),
    .run   (run),
    .done  (done)
  );

  dataPath uData (
    .clock (clock),
    .arstN (arstN),
    .ctl   (ctlBus.data),
    .mem   (memBus.src)
  );

  memPort uMem (
    .clock (clock),
    .arstN (arstN),
    .mem   (memBus.port),
    .awAddr (awAddr), .awValid (awValid), .awReady (awReady),
    .wData  (wData),  .wStrb   (wStrb),   .wValid  (wValid), .wReady (wReady),
    .bResp  (bResp),  .bValid  (bValid),  .bReady  (bReady),
    .arAddr (arAddr), .arValid (arValid), .arReady (arReady),
    .rData  (rData),  .rResp   (rResp),   .rValid  (rValid), .rReady (rReady)
  );

endmodule

// ==== hw/dataPath.sv ====
// Datapath with register file, shared bus, A and G registers, ALU, ADDR and DOUT
`timescale 1ns/1ps

module dataPath (
  input  logic   clock,
  input  logic   arstN,
  cpuCtrlIf.data ctl,
  memReqIf.src   mem
);

  logic [cpuPkg::dataWidth-1:0] gpr [cpuPkg::numRegs-1]; // R0..R6
  logic [cpuPkg::dataWidth-1:0] pc;                      // R7
  logic [cpuPkg::dataWidth-1:0] regView [cpuPkg::numRegs];
  logic [cpuPkg::dataWidth-1:0] bus;
  logic [cpuPkg::dataWidth-1:0] aReg;
  logic [cpuPkg::dataWidth-1:0] gReg;
  logic [cpuPkg::dataWidth-1:0] addrReg;
  logic [cpuPkg::dataWidth-1:0] doutReg;
  cpuPkg::memWordT              aluResult;

  always_comb
  begin
    for (int i = 0; i < cpuPkg::numRegs - 1; i++)
      regView[i] = gpr[i];
    regView[cpuPkg::pcIndex] = pc;
  end

  // Bus source, at most one active
  always_comb
  begin
    bus = '0;
    if (ctl.gOut)
      bus = gReg;
    else if (ctl.dinOut)
      bus = mem.rdata;
    else
      for (int i = 0; i < cpuPkg::numRegs; i++)
        if (ctl.rOut[i])
          bus = bus | regView[i];
  end

  always_comb
  begin
    aluResult = '0;
    case (ctl.aluOp)
      cpuPkg::aluAdd: aluResult.data = aReg + bus; // Wraps at 16 bits
      cpuPkg::aluSub: aluResult.data = aReg - bus;
      cpuPkg::aluSlt: aluResult.data[0] = $signed(aReg) < $signed(bus);
      cpuPkg::aluCmp: aluResult.data[0] = aReg == bus;
    endcase
  end

  always_ff @(posedge clock)
  begin
    for (int i = 0; i < cpuPkg::numRegs - 1; i++)
      if (ctl.rIn[i])
        gpr[i] <= bus;
    if (ctl.aIn)
      aReg <= bus;
    if (ctl.addrIn)
      addrReg <= bus;
    if (ctl.doutIn)
      doutReg <= bus;
  end

  // PC and G, both read by control
  always_ff @(posedge clock or negedge arstN)
  begin
    if (!arstN)
    begin
      pc   <= '0;
      gReg <= '0;
    end
    else
    begin
      if (ctl.rIn[cpuPkg::pcIndex])
        pc <= bus; // Bus load wins over increment
      else if (ctl.incrPc)
        pc <= pc + 1'b1;
      if (ctl.gIn)
        gReg <= aluResult.data;
    end
  end

  assign ctl.gNonZero = |gReg;
  assign mem.addr     = addrReg; // Stable while a request is out
  assign mem.wdata    = doutReg;

endmodule

// ==== hw/memPort.sv ====
// AXI4-Lite master turning single read and write requests into channel handshakes
`timescale 1ns/1ps

module memPort (
  input  logic                              clock,
  input  logic                              arstN,
  memReqIf.port                             mem,
  output logic [cpuPkg::axiAddrWidth-1:0]   awAddr,
  output logic                              awValid,
  input  logic                              awReady,
  output logic [cpuPkg::axiDataWidth-1:0]   wData,
  output logic [3:0]                        wStrb,
  output logic                              wValid,
  input  logic                              wReady,
  input  logic [1:0]                        bResp,
  input  logic                              bValid,
  output logic                              bReady,
  output logic [cpuPkg::axiAddrWidth-1:0]   arAddr,
  output logic                              arValid,
  input  logic                              arReady,
  input  logic [cpuPkg::axiDataWidth-1:0]   rData,
  input  logic [1:0]                        rResp,
  input  logic                              rValid,
  output logic                              rReady
);

  logic [cpuPkg::axiAddrWidth-1:0] byteAddr;
  logic                            awLast;  // AW done or finishing now
  logic                            wLast;   // W done or finishing now
  logic                            rFire;
  logic                            bFire;

  assign byteAddr = {{(cpuPkg::axiAddrWidth - cpuPkg::dataWidth - 2){1'b0}}, mem.addr, 2'b00};
  assign awAddr   = byteAddr;
  assign arAddr   = byteAddr;
  assign wData    = {{(cpuPkg::axiDataWidth - cpuPkg::dataWidth){1'b0}}, mem.wdata};
  assign wStrb    = 4'b0011; // Low half word only
  assign awLast   = !awValid || awReady;
  assign wLast    = !wValid || wReady;
  assign rFire    = rValid && rReady;
  assign bFire    = bValid && bReady;

  // Read side: AR then R
  always_ff @(posedge clock or negedge arstN)
  begin
    if (!arstN)
    begin
      arValid <= 1'b0;
      rReady  <= 1'b0;
    end
    else
    begin
      if (mem.rdStart)
        arValid <= 1'b1;
      else if (arReady)
        arValid <= 1'b0;
      if (arValid && arReady)
        rReady <= 1'b1;
      else if (rFire)
        rReady <= 1'b0;
    end
  end

  // Write side: AW and W together, each drops on own ready, then B
  always_ff @(posedge clock or negedge arstN)
  begin
    if (!arstN)
    begin
      awValid     <= 1'b0;
      wValid      <= 1'b0;
      bReady      <= 1'b0;
      mem.memDone <= 1'b0;
    end
    else
    begin
      if (mem.wrStart)
        awValid <= 1'b1;
      else if (awReady)
        awValid <= 1'b0;
      if (mem.wrStart)
        wValid <= 1'b1;
      else if (wReady)
        wValid <= 1'b0;
      if ((awValid || wValid) && awLast && wLast)
        bReady <= 1'b1; // Last of AW/W just went through
      else if (bFire)
        bReady <= 1'b0;
      mem.memDone <= rFire || bFire; // Any response still counts as done
    end
  end

  always_ff @(posedge clock)
  begin
    if (rFire)
      mem.rdata <= (rResp == cpuPkg::axiRespOkay) ? rData[cpuPkg::dataWidth-1:0] : '0;
  end

endmodule

// ==== project.f ====
hw/cpuPkg.sv
hw/cpuIfs.sv
hw/controlUnit.sv
hw/dataPath.sv
hw/memPort.sv
hw/cpuTop.sv
bench/cpuProperties.sv
bench/cpuTb.sv
